// File: rtl/fp_format_pkg.sv
// Single-precision widths, field types, rounding-mode enum, flag struct and constants
`default_nettype none

package fp_format_pkg;

  // ====================================================================
  // Field widths
  // ====================================================================
  localparam int ExpBits = 8;
  localparam int FracBits = 23;
  // Fraction plus hidden bit
  localparam int MantBits = FracBits + 1;
  // Mantissa plus guard, round and one extra bit
  localparam int RootBits = MantBits + 3;
  // Signed exponent with headroom for the odd/even adjust
  localparam int ExpExtBits = ExpBits + 2;
  localparam int ExpBias = 127;

  // ====================================================================
  // Types
  // ====================================================================
  typedef logic [ExpBits+FracBits:0] fp_word_t;
  typedef logic signed [ExpExtBits-1:0] exp_ext_t;
  typedef logic [RootBits-1:0] root_t;
  // Mantissa, doubled when the unbiased exponent is odd
  typedef logic [MantBits:0] radicand_mant_t;

  localparam fp_word_t CanonicalNan = 32'h7FC0_0000;
  localparam fp_word_t PosInf = 32'h7F80_0000;

  typedef enum logic [2:0] {
    RM_RNE = 3'd0,
    RM_RTZ = 3'd1,
    RM_RDN = 3'd2,
    RM_RUP = 3'd3,
    RM_RMM = 3'd4
  } round_mode_e;

  // Exception flags, nv in the top bit
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_t;

endpackage

`default_nettype wire

// File: rtl/sqrt_ctrl_pkg.sv
// Sequencer state enum, iteration count and counter type for the square root unit
`default_nettype none

package sqrt_ctrl_pkg;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SETUP,
    ST_PREP,
    ST_COMPUTE,
    ST_ROUND,
    ST_APPLY,
    ST_DONE
  } sqrt_state_e;

  // One recurrence cycle per root bit
  localparam int IterCount = fp_format_pkg::RootBits;
  typedef logic [$clog2(IterCount)-1:0] iter_cnt_t;

endpackage

`default_nettype wire

// File: rtl/sqrt_prep_if.sv
// Interface carrying the prepared operand from the unpack stage to the rest of the unit
`timescale 1ns/100ps
`default_nettype none

interface sqrt_prep_if;
  import fp_format_pkg::*;

  logic           is_special;
  fp_word_t       special_result;
  logic           special_invalid;
  // Biased result exponent, already halved
  exp_ext_t       half_exp;
  radicand_mant_t radicand_mant;
  round_mode_e    rm;

  modport producer (
    output is_special, special_result, special_invalid, half_exp, radicand_mant, rm
  );
  modport recurrence (input radicand_mant);
  modport rounding (input special_result, special_invalid, half_exp, rm);
  modport sequencer (input is_special);

endinterface

`default_nettype wire

// File: rtl/sqrt_unpack.sv
// Operand capture, classification, subnormal normalization, special results, exponent halving
`timescale 1ns/100ps
`default_nettype none

module sqrt_unpack (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_capture,
  input  logic                       i_setup,
  input  fp_format_pkg::fp_word_t    i_operand,
  input  fp_format_pkg::round_mode_e i_rounding_mode,
  sqrt_prep_if.producer              prep
);
  import fp_format_pkg::*;

  localparam int LzcBits = $clog2(FracBits + 1);

  fp_word_t           operand_q;
  round_mode_e        rm_q;
  logic               sign;
  logic [ExpBits-1:0] exp_f;
  logic [FracBits-1:0] frac;
  logic               exp_zero;
  logic               exp_ones;
  logic               frac_zero;
  logic               is_zero;
  logic               is_sub;
  logic               is_inf;
  logic               is_nan;
  logic               is_snan;
  logic [LzcBits-1:0] lzc;
  logic [MantBits-1:0] mant_norm;
  exp_ext_t           exp_adj;
  exp_ext_t           exp_unb;
  exp_ext_t           exp_sum;
  radicand_mant_t     radicand_mant;
  logic               is_special;
  fp_word_t           special_result;
  logic               special_invalid;

  // Leading zeros of the fraction, highest set bit wins
  function automatic logic [LzcBits-1:0] frac_lzc(input logic [FracBits-1:0] f);
    logic [LzcBits-1:0] cnt;
    cnt = LzcBits'(FracBits);
    for (int i = 0; i < FracBits; i++) begin
      if (f[i]) begin
        cnt = LzcBits'(FracBits - 1 - i);
      end
    end
    return cnt;
  endfunction

  // Operand and rounding mode held for the whole operation
  always_ff @(posedge i_clk) begin
    if (i_capture) begin
      operand_q <= i_operand;
      rm_q      <= i_rounding_mode;
    end
  end

  // ====================================================================
  // Field split and classification
  // ====================================================================
  assign sign      = operand_q[ExpBits+FracBits];
  assign exp_f     = operand_q[FracBits +: ExpBits];
  assign frac      = operand_q[FracBits-1:0];
  assign exp_zero  = (exp_f == '0);
  assign exp_ones  = (exp_f == '1);
  assign frac_zero = (frac == '0);
  assign is_zero   = exp_zero & frac_zero;
  assign is_sub    = exp_zero & ~frac_zero;
  assign is_inf    = exp_ones & frac_zero;
  assign is_nan    = exp_ones & ~frac_zero;
  // Quiet bit clear marks a signaling NaN
  assign is_snan   = is_nan & ~frac[FracBits-1];

  // ====================================================================
  // Normalization and exponent parity
  // ====================================================================
  always_comb begin
    lzc = frac_lzc(frac);
    if (is_sub) begin
      // Move the leading one up to the hidden-bit position
      mant_norm = {1'b0, frac} << (lzc + 1'b1);
      exp_adj   = exp_ext_t'(0) - exp_ext_t'(lzc);
    end else begin
      mant_norm = {1'b1, frac};
      exp_adj   = exp_ext_t'(exp_f);
    end
    exp_unb = exp_adj - exp_ext_t'(ExpBias);
    if (exp_unb[0]) begin
      // Odd exponent, mantissa scaled by 2 into [2,4)
      radicand_mant = {mant_norm, 1'b0};
      exp_sum       = exp_adj + exp_ext_t'(ExpBias - 1);
    end else begin
      radicand_mant = {1'b0, mant_norm};
      exp_sum       = exp_adj + exp_ext_t'(ExpBias);
    end
  end

  // Special operands in priority order
  always_comb begin
    is_special      = 1'b1;
    special_invalid = 1'b0;
    special_result  = CanonicalNan;
    if (is_nan) begin
      special_invalid = is_snan;
    end else if (sign && !is_zero) begin
      special_invalid = 1'b1;
    end else if (is_inf) begin
      special_result = PosInf;
    end else if (is_zero) begin
      // Signed zero passes through
      special_result = operand_q;
    end else begin
      is_special = 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_setup) begin
      prep.is_special      <= is_special;
      prep.special_result  <= special_result;
      prep.special_invalid <= special_invalid;
      // Sum is always even here, so the halving is exact
      prep.half_exp        <= exp_sum >>> 1;
      prep.radicand_mant   <= radicand_mant;
      prep.rm              <= rm_q;
    end
  end

  a_legal_rm: assert property (@(posedge i_clk) disable iff (i_rst)
    i_capture |-> (i_rounding_mode <= RM_RMM));

endmodule

`default_nettype wire

// File: rtl/sqrt_recurrence.sv
// Non-restoring digit recurrence producing one root bit per cycle
`timescale 1ns/100ps
`default_nettype none

module sqrt_recurrence (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_init,
  input  logic                 i_iterate,
  sqrt_prep_if.recurrence      prep,
  output fp_format_pkg::root_t o_root,
  output logic                 o_rem_nonzero
);
  import fp_format_pkg::*;

  // Radicand holds two bits per root bit
  localparam int RadBits = 2 * RootBits;
  // Partial remainder never exceeds twice the root, plus the two new bits
  localparam int RemBits = RootBits + 3;

  logic [RadBits-1:0] radicand;
  logic [RemBits-1:0] remainder;
  logic [RemBits-1:0] rem_candidate;
  logic [RemBits-1:0] trial;
  logic               fits;

  // Bring down the next two radicand bits
  assign rem_candidate = {remainder[RemBits-3:0], radicand[RadBits-1 -: 2]};
  // Trial divisor is the root followed by 01
  assign trial = {1'b0, o_root, 2'b01};
  assign fits  = (rem_candidate >= trial);

  always_ff @(posedge i_clk) begin
    if (i_init) begin
      o_root    <= '0;
      remainder <= '0;
      // Integer part of the mantissa lands in the top two bits
      radicand  <= {prep.radicand_mant, {(RadBits - MantBits - 1){1'b0}}};
    end else if (i_iterate) begin
      radicand <= {radicand[RadBits-3:0], 2'b00};
      if (fits) begin
        remainder <= rem_candidate - trial;
        o_root    <= {o_root[RootBits-2:0], 1'b1};
      end else begin
        remainder <= rem_candidate;
        o_root    <= {o_root[RootBits-2:0], 1'b0};
      end
    end
  end

  // Any leftover remainder feeds the sticky bit
  assign o_rem_nonzero = |remainder;

  // Radicand in [1,4) gives a root in [1,2), so no normalize cycle is needed
  a_root_normalized: assert property (@(posedge i_clk) disable iff (i_rst)
    $fell(i_iterate) |-> o_root[RootBits-1]);

endmodule

`default_nettype wire

// File: rtl/sqrt_round.sv
// Round-up decision, rounding increment, result packing and result/flag registers
`timescale 1ns/100ps
`default_nettype none

module sqrt_round (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_round,
  input  logic                      i_apply,
  input  logic                      i_load_special,
  input  fp_format_pkg::root_t      i_root,
  input  logic                      i_rem_nonzero,
  sqrt_prep_if.rounding             prep,
  output fp_format_pkg::fp_word_t   o_result,
  output fp_format_pkg::fp_flags_t  o_flags
);
  import fp_format_pkg::*;

  logic [MantBits-1:0] mant;
  logic                guard;
  logic                rnd;
  logic                sticky;
  logic                round_up;
  logic                inexact;
  logic                round_up_q;
  logic                inexact_q;
  logic [MantBits:0]   mant_sum;
  logic [ExpBits-1:0]  exp_out;

  // ====================================================================
  // Round-up decision, result is always positive
  // ====================================================================
  assign mant    = i_root[RootBits-1 -: MantBits];
  assign guard   = i_root[2];
  assign rnd     = i_root[1];
  assign sticky  = i_root[0] | i_rem_nonzero;
  assign inexact = guard | rnd | sticky;

  always_comb begin
    case (prep.rm)
      RM_RNE:         round_up = guard & (rnd | sticky | mant[0]);
      RM_RTZ, RM_RDN: round_up = 1'b0;
      RM_RUP:         round_up = inexact;
      RM_RMM:         round_up = guard;
      default:        round_up = 1'b0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_round) begin
      round_up_q <= round_up;
      inexact_q  <= inexact;
    end
  end

  // ====================================================================
  // Increment and packing
  // ====================================================================
  assign mant_sum = {1'b0, mant} + {{MantBits{1'b0}}, round_up_q};
  // Mantissa carry bumps the exponent
  assign exp_out  = prep.half_exp[ExpBits-1:0] + {{(ExpBits-1){1'b0}}, mant_sum[MantBits]};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_result <= '0;
      o_flags  <= '0;
    end else if (i_load_special) begin
      o_result <= prep.special_result;
      o_flags  <= '{nv: prep.special_invalid, default: 1'b0};
    end else if (i_apply) begin
      // On a carry the low fraction bits are already zero
      o_result <= {1'b0, exp_out, mant_sum[FracBits-1:0]};
      o_flags  <= '{nx: inexact_q, default: 1'b0};
    end
  end

endmodule

`default_nettype wire

// File: rtl/sqrt_control.sv
// Sequencer FSM, iteration counter, stage strobes, valid pulse and stall
`timescale 1ns/100ps
`default_nettype none

module sqrt_control (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_valid,
  sqrt_prep_if.sequencer prep,
  output logic           o_capture,
  output logic           o_setup,
  output logic           o_init,
  output logic           o_load_special,
  output logic           o_iterate,
  output logic           o_round,
  output logic           o_apply,
  output logic           o_valid,
  output logic           o_stall
);
  import sqrt_ctrl_pkg::*;

  sqrt_state_e state;
  sqrt_state_e state_nxt;
  iter_cnt_t   iter_cnt;
  logic        last_iter;

  assign last_iter = (iter_cnt == iter_cnt_t'(IterCount - 1));

  // ====================================================================
  // State machine
  // ====================================================================
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:    if (i_valid) state_nxt = ST_SETUP;
      ST_SETUP:   state_nxt = ST_PREP;
      ST_PREP:    state_nxt = prep.is_special ? ST_DONE : ST_COMPUTE;
      ST_COMPUTE: if (last_iter) state_nxt = ST_ROUND;
      ST_ROUND:   state_nxt = ST_APPLY;
      ST_APPLY:   state_nxt = ST_DONE;
      ST_DONE:    state_nxt = ST_IDLE;
      default:    state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= ST_IDLE;
      iter_cnt <= '0;
      o_valid  <= 1'b0;
    end else begin
      state   <= state_nxt;
      o_valid <= (state == ST_DONE);
      if (o_init) begin
        iter_cnt <= '0;
      end else if (o_iterate) begin
        iter_cnt <= iter_cnt + 1'b1;
      end
    end
  end

  // Stage strobes
  assign o_capture      = (state == ST_IDLE) & i_valid;
  assign o_setup        = (state == ST_SETUP);
  assign o_init         = (state == ST_PREP) & ~prep.is_special;
  assign o_load_special = (state == ST_PREP) & prep.is_special;
  assign o_iterate      = (state == ST_COMPUTE);
  assign o_round        = (state == ST_ROUND);
  assign o_apply        = (state == ST_APPLY);

  // Stall from the accepting cycle until the result pulse
  assign o_stall = ((state != ST_IDLE) | i_valid) & ~o_valid;

  a_valid_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
    o_valid |=> !o_valid);

endmodule

`default_nettype wire

// File: rtl/fp_sqrt.sv
// Single-precision square root top level wiring the unpack, recurrence, round and control stages
`timescale 1ns/100ps
`default_nettype none

module fp_sqrt (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_valid,
  input  fp_format_pkg::fp_word_t    i_operand,
  input  fp_format_pkg::round_mode_e i_rounding_mode,
  output fp_format_pkg::fp_word_t    o_result,
  output fp_format_pkg::fp_flags_t   o_flags,
  output logic                       o_valid,
  output logic                       o_stall
);
  import fp_format_pkg::*;

  // Stage strobes from the sequencer
  logic  capture;
  logic  setup;
  logic  init;
  logic  load_special;
  logic  iterate;
  logic  round;
  logic  apply;
  // Recurrence results
  root_t root;
  logic  rem_nonzero;

  sqrt_prep_if u_prep_if ();

  sqrt_unpack u_unpack (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_capture       (capture),
    .i_setup         (setup),
    .i_operand       (i_operand),
    .i_rounding_mode (i_rounding_mode),
    .prep            (u_prep_if)
  );

  sqrt_recurrence u_recurrence (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_init        (init),
    .i_iterate     (iterate),
    .prep          (u_prep_if),
    .o_root        (root),
    .o_rem_nonzero (rem_nonzero)
  );

  sqrt_round u_round (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_round        (round),
    .i_apply        (apply),
    .i_load_special (load_special),
    .i_root         (root),
    .i_rem_nonzero  (rem_nonzero),
    .prep           (u_prep_if),
    .o_result       (o_result),
    .o_flags        (o_flags)
  );

  sqrt_control u_control (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_valid        (i_valid),
    .prep           (u_prep_if),
    .o_capture      (capture),
    .o_setup        (setup),
    .o_init         (init),
    .o_load_special (load_special),
    .o_iterate      (iterate),
    .o_round        (round),
    .o_apply        (apply),
    .o_valid        (o_valid),
    .o_stall        (o_stall)
  );

endmodule

`default_nettype wire

// File: bench/tb_fp_sqrt.sv
// Self-checking testbench for fp_sqrt with vectors and expected values from a data file
`timescale 1ns/100ps
`default_nettype none

module tb_fp_sqrt;
  import fp_format_pkg::*;

  localparam int ClkPeriod    = 4;
  localparam int ResetCycles  = 4;
  localparam int NumVectors   = 24;
  // Four words per vector for operand, rounding mode, result and flags
  localparam int VecWords     = 4;
  localparam int MaxEdges     = 40;
  // Edge after acceptance at which o_valid is first seen high
  localparam int NormalEdges  = 33;
  localparam int SpecialEdges = 4;
  localparam int WatchdogNs   = (NumVectors * MaxEdges + ResetCycles) * ClkPeriod;

  logic        i_clk;
  logic        i_rst;
  logic        i_valid;
  fp_word_t    i_operand;
  round_mode_e i_rounding_mode;
  fp_word_t    o_result;
  fp_flags_t   o_flags;
  logic        o_valid;
  logic        o_stall;

  logic [31:0] vec_mem [0:NumVectors*VecWords-1];
  integer      seed;
  int          error_count;
  int          failed_tests;
  logic        test_failed;

  fp_sqrt u_fp_sqrt (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_valid         (i_valid),
    .i_operand       (i_operand),
    .i_rounding_mode (i_rounding_mode),
    .o_result        (o_result),
    .o_flags         (o_flags),
    .o_valid         (o_valid),
    .o_stall         (o_stall)
  );

  initial begin
    i_clk = 1'b0;
    forever #(ClkPeriod / 2) i_clk = ~i_clk;
  end

  // Ends a run that stopped making progress
  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns, the run did not complete", WatchdogNs);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // ====================================================================
  // Checks
  // ====================================================================
  task automatic record_failure();
    error_count++;
    test_failed = 1'b1;
  endtask

  task automatic check_result(input fp_word_t got, input fp_word_t expected);
    if (got !== expected) begin
      $display("Error: o_result = %h, expected %h", got, expected);
      record_failure();
    end
  endtask

  task automatic check_flags(input fp_flags_t got, input fp_flags_t expected);
    if (got !== expected) begin
      $display("Error: o_flags = %h, expected %h", got, expected);
      record_failure();
    end
  endtask

  // NaN, infinity, any zero or any negative value skips the recurrence
  function automatic logic is_special_operand(input fp_word_t op);
    return (op[FracBits +: ExpBits] == '1) || (op[ExpBits+FracBits-1:0] == '0) ||
           op[ExpBits+FracBits];
  endfunction

  task automatic check_idle_after_reset();
    test_failed = 1'b0;
    if (o_valid !== 1'b0 || o_stall !== 1'b0) begin
      $display("After reset o_valid or o_stall is not low");
      record_failure();
    end
    check_result(o_result, '0);
    check_flags(o_flags, '0);
    failed_tests += int'(test_failed);
    $display("reset: %s", test_failed ? "FAIL" : "ok");
  endtask

  // ====================================================================
  // One vector with an optional second request held while busy
  // ====================================================================
  task automatic run_vector(input int idx);
    fp_word_t    operand;
    round_mode_e rm;
    fp_word_t    exp_result;
    fp_flags_t   exp_flags;
    int          edge_idx;
    int          want_edges;
    logic        seen;
    logic        hold_req;
    logic        stall_bad;
    operand    = vec_mem[VecWords*idx];
    rm         = round_mode_e'(vec_mem[VecWords*idx+1][2:0]);
    exp_result = vec_mem[VecWords*idx+2];
    exp_flags  = fp_flags_t'(vec_mem[VecWords*idx+3][4:0]);
    want_edges = is_special_operand(operand) ? SpecialEdges : NormalEdges;
    hold_req   = idx[0];
    test_failed = 1'b0;
    stall_bad   = 1'b0;
    seen        = 1'b0;
    edge_idx    = -1;
    // The next edge accepts the request and counts as edge 0
    i_valid         <= 1'b1;
    i_operand       <= operand;
    i_rounding_mode <= rm;
    while (!seen && edge_idx < MaxEdges) begin
      @(posedge i_clk);
      edge_idx++;
      if (o_valid) begin
        seen = 1'b1;
      end else begin
        if (!o_stall) begin
          stall_bad = 1'b1;
        end
        // A request held while busy must be ignored
        i_valid   <= hold_req && (edge_idx < want_edges - 1);
        i_operand <= ~operand;
      end
    end
    if (!seen) begin
      $display("No o_valid within %0d cycles of the request", MaxEdges);
      record_failure();
    end else begin
      if (edge_idx != want_edges) begin
        $display("o_valid came %0d edges after acceptance instead of %0d",
                 edge_idx, want_edges);
        record_failure();
      end
      if (o_stall) begin
        $display("o_stall is still high while o_valid is high");
        record_failure();
      end
      check_result(o_result, exp_result);
      check_flags(o_flags, exp_flags);
    end
    if (stall_bad) begin
      $display("o_stall dropped while the unit was busy");
      record_failure();
    end
    failed_tests += int'(test_failed);
    $display("test %0d: sqrt(%h) %s -> %h flags %h: %s", idx, operand, rm.name(),
             o_result, o_flags, test_failed ? "FAIL" : "ok");
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial begin
    int gap;
    seed         = 32'ha1db;
    error_count  = 0;
    failed_tests = 0;
    test_failed  = 1'b0;
    i_rst           <= 1'b1;
    i_valid         <= 1'b0;
    i_operand       <= '0;
    i_rounding_mode <= RM_RNE;
    $readmemh("bench/fp_sqrt_testdata.hex", vec_mem);
    repeat (ResetCycles) @(posedge i_clk);
    i_rst <= 1'b0;
    @(posedge i_clk);
    check_idle_after_reset();
    for (int idx = 0; idx < NumVectors; idx++) begin
      // Idle gap of 0 to 3 cycles
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(posedge i_clk);
      run_vector(idx);
    end
    $display("%0d tests run, %0d failed, %0d errors", NumVectors + 1, failed_tests,
             error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/fp_sqrt_testdata.hex
// operand  rounding-mode (0 RNE 1 RTZ 2 RDN 3 RUP 4 RMM)  expected-result  expected-flags
// flags bits from the top: nv dz of uf nx
40800000 0 40000000 00
41100000 1 40400000 00
3E800000 2 3F000000 00
40100000 3 3FC00000 00
41100000 4 40400000 00
40000000 0 3FB504F3 01
40000000 1 3FB504F3 01
40000000 2 3FB504F3 01
40000000 3 3FB504F4 01
40000000 4 3FB504F3 01
40400000 0 3FDDB3D7 01
40400000 3 3FDDB3D8 01
40A00000 0 400F1BBD 01
40A00000 1 400F1BBC 01
40A00000 4 400F1BBD 01
00000000 0 00000000 00
80000000 0 80000000 00
7F800000 0 7F800000 00
7FC00000 0 7FC00000 00
7F800001 0 7FC00000 10
BF800000 0 7FC00000 10
00000001 0 1A3504F3 01
00000002 0 1A800000 00
00400000 3 1FB504F4 01

// File: fp_sqrt.f
rtl/fp_format_pkg.sv
rtl/sqrt_ctrl_pkg.sv
rtl/sqrt_prep_if.sv
rtl/sqrt_unpack.sv
rtl/sqrt_recurrence.sv
rtl/sqrt_round.sv
rtl/sqrt_control.sv
rtl/fp_sqrt.sv
bench/tb_fp_sqrt.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_fp_sqrt
FILELIST  = fp_sqrt.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
